// ==== Makefile ====
SRCS := $(shell grep -v '^+' execUnit.f)

.PHONY: all run clean

all: obj_dir/VexecUnitTb

obj_dir/VexecUnitTb: execUnit.f $(SRCS)
	verilator --binary --timing --assert -f execUnit.f --top-module execUnitTb -o VexecUnitTb

run: obj_dir/VexecUnitTb
	@out=$$(./obj_dir/VexecUnitTb); echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

// ==== alu/aluUnits.sv ====
`timescale 1ns/1ps

module aluUnits (
   operandIf.sink          ops,
   input  isaPkg::unitSelT unitSel,
   input  logic            carryFlag,
   input  logic [31:0]     msrWord,
   input  logic [29:0]     pc,
   input  logic [31:0]     bsResult,
   output logic [31:0]     xResult,
   output logic [31:0]     sum,
   output logic            addCarry,
   output logic            shiftCarry
);
   isaPkg::shiftKindT   kind;
   logic [31:0]         logicRes;
   logic [31:0]         shiftRes;
   logic [31:0]         moveRes;

   assign {addCarry, sum} = {1'b0, ops.opB} + {1'b0, ops.opA} + 33'(ops.carryIn);

   always_comb begin
      unique case (ops.opcode)
         isaPkg::opAnd:  logicRes = ops.opA & ops.opB;
         isaPkg::opXor:  logicRes = ops.opA ^ ops.opB;
         isaPkg::opAndn: logicRes = ops.opA & ~ops.opB;
         default:        logicRes = ops.opA | ops.opB;
      endcase
   end

   // One-bit right shifts go out through carry
   assign kind = isaPkg::shiftKindT'(ops.imm[6:5]);

   always_comb begin
      shiftCarry = ops.opA[0];
      unique case (kind)
         isaPkg::skSra: shiftRes = {ops.opA[31], ops.opA[31:1]};
         isaPkg::skSrc: shiftRes = {carryFlag, ops.opA[31:1]};
         isaPkg::skSrl: shiftRes = {1'b0, ops.opA[31:1]};
         isaPkg::skSext: begin
            shiftCarry = carryFlag; // Sign extension keeps carry
            if (ops.imm[0])
               shiftRes = {{16{ops.opA[15]}}, ops.opA[15:0]};
            else
               shiftRes = {{24{ops.opA[7]}}, ops.opA[7:0]};
         end
      endcase
   end

   always_comb begin
      if (ops.opcode == isaPkg::opMfs)
         moveRes = ops.imm[0] ? msrWord : {pc, 2'b00};
      else
         moveRes = ops.ra[3] ? ops.opB : ops.opA;
   end

   always_comb begin
      unique case (unitSel)
         isaPkg::usLogic:  xResult = logicRes;
         isaPkg::usShift:  xResult = shiftRes;
         isaPkg::usMove:   xResult = moveRes;
         isaPkg::usBarrel: xResult = bsResult;
         default:          xResult = sum;
      endcase
   end

endmodule

// ==== alu/barrelShift.sv ====
`timescale 1ns/1ps

module barrelShift #(
   parameter bit BarrelEn = 1'b1
) (
   input  logic         gclk,
   input  logic         grst,
   operandIf.sink       ops,
   input  logic [1:0]   kind, // 0 logical right, 1 arithmetic right, 2 left
   output logic [31:0]  bsResult
);

   generate
      if (BarrelEn) begin : genShifter
         logic [4:0] amount;

         assign amount = ops.opB[4:0];

         always_ff @(posedge gclk) begin
            if (grst)
               bsResult <= '0;
            else begin
               unique case (kind)
                  2'd0: bsResult <= ops.opA >> amount;
                  2'd1: bsResult <= $unsigned($signed(ops.opA) >>> amount);
                  2'd2: bsResult <= ops.opA << amount;
                  default: bsResult <= '0;
               endcase
            end
         end
      end else begin : genNoShifter
         assign bsResult = '0;
      end
   endgenerate

endmodule

// ==== common/dataBusPkg.sv ====
package dataBusPkg;

   localparam int DataWidth = 32;

   // Taken from the low two opcode bits of a load or store
   typedef enum logic [1:0] {
      asByte   = 2'd0,
      asHalf   = 2'd1,
      asWord   = 2'd2,
      asStream = 2'd3
   } accessSizeT;

   typedef logic [3:0] laneT;

   // Big-endian lanes with bit 3 as the byte at address offset 0
   localparam laneT LaneNone = 4'h0;
   localparam laneT LaneByte0 = 4'h8;
   localparam laneT LaneHalfHi = 4'hC;
   localparam laneT LaneHalfLo = 4'h3;
   localparam laneT LaneWord = 4'hF;

endpackage

// ==== common/isaPkg.sv ====
package isaPkg;

   // Opcodes of the instruction subset handled by the execute stage
   typedef enum logic [5:0] {
      opAdd    = 6'o00,
      opRsub   = 6'o01,
      opAddc   = 6'o02,
      opRsubc  = 6'o03,
      opAddi   = 6'o10,
      opRsubi  = 6'o11,
      opAddic  = 6'o12,
      opRsubic = 6'o13,
      opBsr    = 6'o20, // Low two bits give the barrel kind
      opBsra   = 6'o21,
      opBsl    = 6'o22,
      opOr     = 6'o40,
      opAnd    = 6'o41,
      opXor    = 6'o42,
      opAndn   = 6'o43,
      opShift  = 6'o44, // Kind in imm[6:5]
      opMfs    = 6'o45, // imm[0] set reads MSR, clear reads PC
      opBrk    = 6'o46,
      opMts    = 6'o47, // imm[0] set writes MSR
      opRtid   = 6'o55,
      opBrki   = 6'o56,
      opRtbd   = 6'o57,
      opLbu    = 6'o60,
      opLhu    = 6'o61,
      opLw     = 6'o62,
      opSb     = 6'o64,
      opSh     = 6'o65,
      opSw     = 6'o66
   } opcodeT;

   typedef enum logic [2:0] {usAdd, usLogic, usShift, usMove, usBarrel} unitSelT;
   typedef enum logic [1:0] {srcReg, srcFwd, srcLoad, srcPc} srcSelT;
   typedef enum logic [1:0] {tgtReg, tgtFwd, tgtLoad, tgtImm} tgtSelT;
   typedef enum logic [1:0] {skSra, skSrc, skSrl, skSext} shiftKindT;

   // MSR layout as read by mfs
   localparam int MsrBe = 0;
   localparam int MsrIe = 1;
   localparam int MsrC = 2;
   localparam int MsrBip = 3;
   localparam int MsrCc = 31; // Carry copy

endpackage

// ==== common/operandIf.sv ====
`timescale 1ns/1ps

// Latched operands and instruction fields of the instruction in execute
interface operandIf;
   logic [31:0]      opA;
   logic [31:0]      opB;
   logic             carryIn;
   isaPkg::opcodeT   opcode;
   logic [15:0]      imm;
   logic [4:0]       ra;
   logic [4:0]       rd;

   modport source (
      output opA, opB, carryIn, opcode, imm, ra, rd
   );

   modport sink (
      input opA, opB, carryIn, opcode, imm, ra, rd
   );
endinterface

// ==== execUnit.f ====
common/isaPkg.sv
common/dataBusPkg.sv
common/operandIf.sv
src/execCtrl.sv
src/operandSelect.sv
alu/aluUnits.sv
alu/barrelShift.sv
src/msrUnit.sv
src/dataLaneSelect.sv
src/execUnit.sv
tb/execUnit_assert.sv
tb/execUnitTb.sv

// ==== src/dataLaneSelect.sv ====
`timescale 1ns/1ps

module dataLaneSelect (
   input  logic                                 gclk,
   input  logic                                 grst,
   input  isaPkg::opcodeT                       opcode,
   input  logic [31:0]                          sum,     // Effective address
   input  logic [31:0]                          xResult,
   output logic [dataBusPkg::DataWidth-1:0]     precycleAddr,
   output dataBusPkg::laneT                     dwbSel
);
   dataBusPkg::accessSizeT size;
   dataBusPkg::laneT       lanes;
   logic                   memOp;

   assign memOp = isMemOp(opcode);
   assign size = dataBusPkg::accessSizeT'(opcode[1:0]);

   function automatic logic isMemOp(input isaPkg::opcodeT op);
      return op inside {isaPkg::opLbu, isaPkg::opLhu, isaPkg::opLw,
                        isaPkg::opSb, isaPkg::opSh, isaPkg::opSw};
   endfunction

   always_comb begin
      unique case (size)
         dataBusPkg::asByte: lanes = dataBusPkg::LaneByte0 >> sum[1:0];
         dataBusPkg::asHalf: lanes = sum[1] ? dataBusPkg::LaneHalfLo : dataBusPkg::LaneHalfHi;
         dataBusPkg::asWord: lanes = dataBusPkg::LaneWord;
         default:            lanes = dataBusPkg::LaneNone;
      endcase
      if (!memOp)
         lanes = dataBusPkg::LaneNone;
   end

   always_ff @(posedge gclk) begin
      if (grst)
         dwbSel <= dataBusPkg::LaneNone;
      else
         dwbSel <= lanes;
   end

   // Cache word address with two spare bits below the top three
   assign precycleAddr = {xResult[31:29], 2'b00, xResult[28:2]};

endmodule

// ==== src/execCtrl.sv ====
`timescale 1ns/1ps

module execCtrl (
   input  logic               gclk,
   input  logic               grst,
   input  logic               dEn,
   input  logic               xEn,
   input  logic               skip,
   input  isaPkg::opcodeT     opcode, // Issuing instruction
   input  logic [15:0]        imm,    // Latched fields of the instruction in execute
   input  logic [4:0]         ra,
   input  logic [4:0]         rd,
   output isaPkg::unitSelT    unitSel,
   output logic               subtract,
   output logic               useCarry,
   output logic               mtsUpd,
   output logic               rtidUpd,
   output logic               rtbdUpd,
   output logic               brkUpd,
   output logic               intUpd,
   output logic               resultEn,
   output logic               stall
);
   typedef enum logic {idle, shiftWait} stateT;

   stateT            state;
   isaPkg::unitSelT  unitDec;
   logic             isMts, isRtid, isRtbd, isBrk;

   // Operand select needs these at issue time
   assign subtract = opcode inside {isaPkg::opRsub, isaPkg::opRsubc,
                                    isaPkg::opRsubi, isaPkg::opRsubic};
   assign useCarry = opcode inside {isaPkg::opAddc, isaPkg::opRsubc,
                                    isaPkg::opAddic, isaPkg::opRsubic};

   always_comb begin
      unique case (opcode)
         isaPkg::opOr, isaPkg::opAnd, isaPkg::opXor, isaPkg::opAndn: unitDec = isaPkg::usLogic;
         isaPkg::opShift: unitDec = isaPkg::usShift;
         isaPkg::opMfs, isaPkg::opMts, isaPkg::opBrk, isaPkg::opBrki,
         isaPkg::opRtid, isaPkg::opRtbd: unitDec = isaPkg::usMove;
         isaPkg::opBsr, isaPkg::opBsra, isaPkg::opBsl: unitDec = isaPkg::usBarrel;
         default: unitDec = isaPkg::usAdd; // Adds, loads and stores
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         unitSel <= isaPkg::usAdd;
         isMts <= 1'b0;
         isRtid <= 1'b0;
         isRtbd <= 1'b0;
         isBrk <= 1'b0;
      end else if (dEn) begin
         unitSel <= unitDec;
         isMts <= opcode == isaPkg::opMts;
         isRtid <= opcode == isaPkg::opRtid;
         isRtbd <= opcode == isaPkg::opRtbd;
         isBrk <= opcode inside {isaPkg::opBrk, isaPkg::opBrki};
      end
   end

   // Status strobes qualified by the latched fields
   assign mtsUpd = isMts & imm[0] & ~skip;
   assign rtidUpd = isRtid & rd[0] & ~skip;
   assign rtbdUpd = isRtbd & rd[1] & ~skip;
   assign brkUpd = isBrk & (ra == 5'h0C) & ~skip;
   assign intUpd = isBrk & (ra == 5'h0E) & ~skip;

   // One wait cycle while the barrel shifter registers
   always_ff @(posedge gclk) begin
      if (grst)
         state <= idle;
      else if (state == shiftWait)
         state <= idle;
      else if (dEn && unitDec == isaPkg::usBarrel)
         state <= shiftWait;
   end

   assign stall = state == shiftWait;
   assign resultEn = xEn & ~stall;

endmodule

// ==== src/execUnit.sv ====
`timescale 1ns/1ps

module execUnit #(
   parameter bit BarrelEn = 1'b1
) (
   input  logic                              gclk,
   input  logic                              grst,
   input  logic                              dEn,
   input  logic                              xEn,
   input  logic                              skip,
   input  isaPkg::opcodeT                    opcode,
   input  logic [15:0]                       imm,
   input  logic [4:0]                        ra,
   input  logic [4:0]                        rd,
   input  isaPkg::srcSelT                    srcSel,
   input  isaPkg::tgtSelT                    tgtSel,
   input  logic [31:0]                       regA,
   input  logic [31:0]                       regB,
   input  logic [31:0]                       loadData,
   input  logic [31:0]                       simm,
   input  logic [29:0]                       pc,     // PC of the issuing instruction
   input  logic [29:0]                       pcExec, // PC of the instruction in execute
   output logic [dataBusPkg::DataWidth-1:0]  precycleAddr,
   output logic [31:0]                       xResult,
   output logic [31:0]                       rResult,
   output dataBusPkg::laneT                  rDwbSel,
   output logic                              rMsrIe,
   output logic                              stall
);
   isaPkg::unitSelT  unitSel;
   logic             subtract, useCarry, resultEn;
   logic             mtsUpd, rtidUpd, rtbdUpd, brkUpd, intUpd;
   logic             carryFlag, addCarry, shiftCarry;
   logic [31:0]      sum, msrWord, bsResult;

   operandIf opsIf ();

   // Opcode comes from issue, the other fields from the latched copy
   execCtrl uCtrl (
      .gclk, .grst, .dEn, .xEn, .skip, .opcode,
      .imm(opsIf.imm), .ra(opsIf.ra), .rd(opsIf.rd),
      .unitSel, .subtract, .useCarry,
      .mtsUpd, .rtidUpd, .rtbdUpd, .brkUpd, .intUpd,
      .resultEn, .stall
   );

   operandSelect uOpSel (
      .gclk, .grst, .dEn, .srcSel, .tgtSel,
      .regA, .regB, .loadData, .simm, .pc, .xResult,
      .subtract, .useCarry, .carryFlag,
      .opcode, .imm, .ra, .rd, .ops(opsIf.source)
   );

   aluUnits uAlu (
      .ops(opsIf.sink), .unitSel, .carryFlag, .msrWord, .pc(pcExec),
      .bsResult, .xResult, .sum, .addCarry, .shiftCarry
   );

   barrelShift #(.BarrelEn(BarrelEn)) uBarrel (
      .gclk, .grst, .ops(opsIf.sink), .kind(opsIf.opcode[1:0]), .bsResult
   );

   msrUnit uMsr (
      .gclk, .grst, .resultEn, .ops(opsIf.sink),
      .unitSel, .addCarry, .shiftCarry,
      .mtsUpd, .rtidUpd, .rtbdUpd, .brkUpd, .intUpd, .skip,
      .xResult, .carryFlag, .intEnable(rMsrIe), .msrWord, .rResult
   );

   dataLaneSelect uLanes (
      .gclk, .grst, .opcode(opsIf.opcode), .sum, .xResult,
      .precycleAddr, .dwbSel(rDwbSel)
   );

endmodule

// ==== src/msrUnit.sv ====
`timescale 1ns/1ps

module msrUnit (
   input  logic               gclk,
   input  logic               grst,
   input  logic               resultEn,
   operandIf.sink             ops,
   input  isaPkg::unitSelT    unitSel,
   input  logic               addCarry,
   input  logic               shiftCarry,
   input  logic               mtsUpd,
   input  logic               rtidUpd,
   input  logic               rtbdUpd,
   input  logic               brkUpd,
   input  logic               intUpd,
   input  logic               skip,
   input  logic [31:0]        xResult,
   output logic               carryFlag,
   output logic               intEnable,
   output logic [31:0]        msrWord,
   output logic [31:0]        rResult
);
   logic    bip, be;
   logic    carryNext, ieNext, bipNext, beNext;
   logic    carryOp;

   // Loads and stores use the adder but leave carry alone
   assign carryOp = ops.opcode inside {isaPkg::opAdd, isaPkg::opRsub, isaPkg::opAddc,
                                       isaPkg::opRsubc, isaPkg::opAddi, isaPkg::opRsubi,
                                       isaPkg::opAddic, isaPkg::opRsubic};

   always_comb begin
      carryNext = carryFlag;
      if (!skip) begin
         unique case (unitSel)
            isaPkg::usAdd:   carryNext = carryOp ? addCarry : carryFlag;
            isaPkg::usShift: carryNext = shiftCarry;
            isaPkg::usMove:  carryNext = mtsUpd ? ops.opA[isaPkg::MsrC] : carryFlag;
            default:         carryNext = carryFlag;
         endcase
      end
   end

   assign ieNext = intUpd ? 1'b0 : rtidUpd ? 1'b1 : mtsUpd ? ops.opA[isaPkg::MsrIe] : intEnable;
   assign bipNext = brkUpd ? 1'b1 : rtbdUpd ? 1'b0 : mtsUpd ? ops.opA[isaPkg::MsrBip] : bip;
   assign beNext = mtsUpd ? ops.opA[isaPkg::MsrBe] : be;

   // Commit point of the stage
   always_ff @(posedge gclk) begin
      if (grst) begin
         carryFlag <= 1'b0;
         intEnable <= 1'b0;
         bip <= 1'b0;
         be <= 1'b0;
         rResult <= '0;
      end else if (resultEn) begin
         carryFlag <= carryNext;
         intEnable <= ieNext;
         bip <= bipNext;
         be <= beNext;
         rResult <= xResult;
      end
   end

   always_comb begin
      msrWord = '0;
      msrWord[isaPkg::MsrCc] = carryFlag;
      msrWord[isaPkg::MsrBip] = bip;
      msrWord[isaPkg::MsrC] = carryFlag;
      msrWord[isaPkg::MsrIe] = intEnable;
      msrWord[isaPkg::MsrBe] = be;
   end

endmodule

// ==== src/operandSelect.sv ====
`timescale 1ns/1ps

module operandSelect (
   input  logic            gclk,
   input  logic            grst,
   input  logic            dEn,
   input  isaPkg::srcSelT  srcSel,
   input  isaPkg::tgtSelT  tgtSel,
   input  logic [31:0]     regA,
   input  logic [31:0]     regB,
   input  logic [31:0]     loadData,
   input  logic [31:0]     simm,
   input  logic [29:0]     pc,
   input  logic [31:0]     xResult,
   input  logic            subtract,
   input  logic            useCarry,
   input  logic            carryFlag,
   input  isaPkg::opcodeT  opcode,
   input  logic [15:0]     imm,
   input  logic [4:0]      ra,
   input  logic [4:0]      rd,
   operandIf.source        ops
);

   always_ff @(posedge gclk) begin
      if (grst) begin
         ops.opA <= '0;
         ops.opB <= '0;
         ops.carryIn <= 1'b0;
         ops.opcode <= isaPkg::opAdd;
         ops.imm <= '0;
         ops.ra <= '0;
         ops.rd <= '0;
      end else if (dEn) begin
         unique case (srcSel)
            isaPkg::srcReg:  ops.opA <= regA;
            isaPkg::srcFwd:  ops.opA <= subtract ? ~xResult : xResult; // Reverse subtract
            isaPkg::srcLoad: ops.opA <= loadData;
            isaPkg::srcPc:   ops.opA <= {pc, 2'b00};
         endcase
         unique case (tgtSel)
            isaPkg::tgtReg:  ops.opB <= regB;
            isaPkg::tgtFwd:  ops.opB <= xResult;
            isaPkg::tgtLoad: ops.opB <= loadData;
            isaPkg::tgtImm:  ops.opB <= simm;
         endcase
         ops.carryIn <= useCarry ? carryFlag : subtract; // +1 completes the negate
         ops.opcode <= opcode;
         ops.imm <= imm;
         ops.ra <= ra;
         ops.rd <= rd;
      end
   end

endmodule

// ==== tb/execUnitTb.sv ====
`timescale 1ns/1ps

module execUnitTb;
   logic gclk, grst, dEn, xEn, skip;
   isaPkg::opcodeT opcode;
   logic [15:0] imm;
   logic [4:0] ra, rd;
   isaPkg::srcSelT srcSel;
   isaPkg::tgtSelT tgtSel;
   logic [31:0] regA, regB, loadData, simm;
   logic [29:0] pc, pcExec;
   logic [31:0] precycleAddr, xResult, rResult;
   logic [3:0] rDwbSel;
   logic rMsrIe, stall;

   logic [31:0] lfsr = 32'hf5d2;
   int edgeCnt = 0;
   int errCnt = 0;
   int checks = 0;
   logic refC, refIe, refBip, refBe;
   logic [31:0] refPrev;
   logic [3:0] expLanes;
   bit prevLive; // Previous xResult follows the live flags

   // Expected values waiting for their commit edge
   int qDue[$];
   logic [31:0] qRes[$];
   logic qC[$], qIe[$];
   logic [3:0] qLanes[$];
   isaPkg::opcodeT qOp[$];

   execUnit #(.BarrelEn(1'b1)) DUT (.*);

   initial begin
      gclk = 1'b0;
      forever #5 gclk = ~gclk;
   end

   always @(posedge gclk) edgeCnt <= edgeCnt + 1;

   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32 22 2 1
   endfunction

   function automatic logic [31:0] randBits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsrStep(lfsr);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   // Model of one instruction that also updates the model flags
   function automatic logic [31:0] refExec(input isaPkg::opcodeT op, input isaPkg::srcSelT s,
         input logic [31:0] aIn, input logic [31:0] b, input logic [15:0] immv,
         input logic [4:0] rav, input logic [4:0] rdv, input bit sk, input logic [29:0] pcx);
      logic [31:0] a, res, msr;
      logic [32:0] full;
      logic sub, useC, cin, cNew, ieNew, bipNew, beNew;
      sub = op inside {isaPkg::opRsub, isaPkg::opRsubc, isaPkg::opRsubi, isaPkg::opRsubic};
      useC = op inside {isaPkg::opAddc, isaPkg::opRsubc, isaPkg::opAddic, isaPkg::opRsubic};
      a = (sub && s == isaPkg::srcFwd) ? ~aIn : aIn;
      cin = useC ? refC : sub;
      full = {1'b0, a} + {1'b0, b} + {32'b0, cin};
      msr = {refC, 27'b0, refBip, refC, refIe, refBe};
      {cNew, ieNew, bipNew, beNew} = {refC, refIe, refBip, refBe};
      res = full[31:0];
      expLanes = 4'h0;
      case (op)
         isaPkg::opAdd, isaPkg::opRsub, isaPkg::opAddc, isaPkg::opRsubc, isaPkg::opAddi,
         isaPkg::opRsubi, isaPkg::opAddic, isaPkg::opRsubic: cNew = full[32];
         isaPkg::opLbu, isaPkg::opSb: expLanes = 4'b1000 >> full[1:0]; // Big-endian lanes
         isaPkg::opLhu, isaPkg::opSh: expLanes = full[1] ? 4'b0011 : 4'b1100;
         isaPkg::opLw, isaPkg::opSw:  expLanes = 4'b1111;
         isaPkg::opOr:   res = a | b;
         isaPkg::opAnd:  res = a & b;
         isaPkg::opXor:  res = a ^ b;
         isaPkg::opAndn: res = a & ~b;
         isaPkg::opShift: begin
            case (immv[6:5])
               2'd0: res = {a[31], a[31:1]};
               2'd1: res = {refC, a[31:1]};
               2'd2: res = {1'b0, a[31:1]};
               default: res = immv[0] ? {{16{a[15]}}, a[15:0]} : {{24{a[7]}}, a[7:0]};
            endcase
            if (immv[6:5] != 2'd3)
               cNew = a[0];
         end
         isaPkg::opMfs: res = immv[0] ? msr : {pcx, 2'b00};
         isaPkg::opBsr:  res = a >> b[4:0];
         isaPkg::opBsra: res = $unsigned($signed(a) >>> b[4:0]);
         isaPkg::opBsl:  res = a << b[4:0];
         default: begin // mts, rtid, rtbd, brk, brki
            res = rav[3] ? b : a;
            if (op == isaPkg::opMts && immv[0])
               {cNew, bipNew, ieNew, beNew} = {a[2], a[3], a[1], a[0]};
            if (op == isaPkg::opRtid && rdv[0])
               ieNew = 1'b1;
            if (op == isaPkg::opRtbd && rdv[1])
               bipNew = 1'b0;
            if (op inside {isaPkg::opBrk, isaPkg::opBrki} && rav == 5'h0C)
               bipNew = 1'b1;
            if (op inside {isaPkg::opBrk, isaPkg::opBrki} && rav == 5'h0E)
               ieNew = 1'b0; // Interrupt form clears IE
         end
      endcase
      if (!sk)
         {refC, refIe, refBip, refBe} = {cNew, ieNew, bipNew, beNew};
      refPrev = res;
      return res;
   endfunction

   task automatic abortRun(input string why);
      $display("Timeout: %s", why);
      $display("Verification failed");
      $finish;
   endtask

   // Issue one instruction and wait for its commit
   task automatic runInstr(input isaPkg::opcodeT op, input isaPkg::srcSelT s,
         input isaPkg::tgtSelT t, input logic [15:0] immv, input logic [4:0] rav,
         input logic [4:0] rdv, input bit sk);
      logic [31:0] aVal, bVal, res;
      bit barrel;
      int stallCycles, waitCnt;
      if (prevLive && s == isaPkg::srcFwd)
         s = isaPkg::srcReg;
      if (prevLive && t == isaPkg::tgtFwd)
         t = isaPkg::tgtReg;
      barrel = op inside {isaPkg::opBsr, isaPkg::opBsra, isaPkg::opBsl};
      regA = randBits(32);
      regB = randBits(32);
      loadData = randBits(32);
      simm = randBits(32);
      pc = 30'(randBits(30));
      pcExec = 30'(randBits(30));
      case (s)
         isaPkg::srcReg:  aVal = regA;
         isaPkg::srcFwd:  aVal = refPrev;
         isaPkg::srcLoad: aVal = loadData;
         default:         aVal = {pc, 2'b00};
      endcase
      case (t)
         isaPkg::tgtReg:  bVal = regB;
         isaPkg::tgtFwd:  bVal = refPrev;
         isaPkg::tgtLoad: bVal = loadData;
         default:         bVal = simm;
      endcase
      opcode = op;
      srcSel = s;
      tgtSel = t;
      imm = immv;
      ra = rav;
      rd = rdv;
      skip = sk;
      dEn = 1'b1;
      xEn = 1'b0;
      res = refExec(op, s, aVal, bVal, immv, rav, rdv, sk, pcExec);
      prevLive = (op == isaPkg::opMfs) || (op == isaPkg::opShift && immv[6:5] == 2'd1);
      qDue.push_back(edgeCnt + 1 + (barrel ? 2 : 1));
      qRes.push_back(res);
      qC.push_back(refC);
      qIe.push_back(refIe);
      qLanes.push_back(expLanes);
      qOp.push_back(op);
      @(posedge gclk);
      #1;
      dEn = 1'b0;
      xEn = 1'b1;
      stallCycles = 0;
      while (stall) begin
         stallCycles++;
         if (stallCycles > 4)
            abortRun("stall never dropped");
         @(posedge gclk);
         #1;
      end
      if (stallCycles != (barrel ? 1 : 0)) begin
         $display("Error: stall lasted %0h cycles, expected %0h", stallCycles, barrel ? 1 : 0);
         errCnt++;
      end
      if (xResult !== res) begin
         $display("Error: xResult %h expected %h (%s)", xResult, res, op.name());
         errCnt++;
      end
      // Early cache address keeps the top three bits above a two-bit gap
      if (precycleAddr !== {res[31:29], 2'b00, res[28:2]}) begin
         $display("Error: precycleAddr %h expected %h (%s)", precycleAddr,
                  {res[31:29], 2'b00, res[28:2]}, op.name());
         errCnt++;
      end
      @(posedge gclk);
      #1;
      xEn = 1'b0;
      waitCnt = 0;
      while (qDue.size() > 0) begin
         waitCnt++;
         if (waitCnt > 8)
            abortRun("result check never happened");
         @(posedge gclk);
         #1;
      end
   endtask

   // Compare at the commit edge of each instruction
   initial begin
      forever begin
         @(posedge gclk);
         #2;
         if (qDue.size() > 0 && qDue[0] == edgeCnt) begin
            checks++;
            if (rResult !== qRes[0]) begin
               $display("Error: rResult %h expected %h (%s)", rResult, qRes[0], qOp[0].name());
               errCnt++;
            end
            if (DUT.uMsr.carryFlag !== qC[0]) begin
               $display("Error: carryFlag %h expected %h (%s)", DUT.uMsr.carryFlag, qC[0],
                        qOp[0].name());
               errCnt++;
            end
            if (rMsrIe !== qIe[0]) begin
               $display("Error: rMsrIe %h expected %h (%s)", rMsrIe, qIe[0], qOp[0].name());
               errCnt++;
            end
            if (rDwbSel !== qLanes[0]) begin
               $display("Error: rDwbSel %h expected %h (%s)", rDwbSel, qLanes[0],
                        qOp[0].name());
               errCnt++;
            end
            void'(qDue.pop_front());
            void'(qRes.pop_front());
            void'(qC.pop_front());
            void'(qIe.pop_front());
            void'(qLanes.pop_front());
            void'(qOp.pop_front());
         end
      end
   end

   initial begin
      #500000;
      abortRun("simulation time limit reached");
   end

   initial begin
      isaPkg::opcodeT addOps[8], logicOps[4], barrelOps[3], memOps[6];
      logic [31:0] r;
      addOps = '{isaPkg::opAdd, isaPkg::opRsub, isaPkg::opAddc, isaPkg::opRsubc,
                 isaPkg::opAddi, isaPkg::opRsubi, isaPkg::opAddic, isaPkg::opRsubic};
      logicOps = '{isaPkg::opOr, isaPkg::opAnd, isaPkg::opXor, isaPkg::opAndn};
      barrelOps = '{isaPkg::opBsr, isaPkg::opBsra, isaPkg::opBsl};
      memOps = '{isaPkg::opLbu, isaPkg::opLhu, isaPkg::opLw,
                 isaPkg::opSb, isaPkg::opSh, isaPkg::opSw};
      {grst, dEn, xEn, skip} = 4'b1000;
      opcode = isaPkg::opAdd;
      {imm, ra, rd} = '0;
      srcSel = isaPkg::srcReg;
      tgtSel = isaPkg::tgtReg;
      {regA, regB, loadData, simm, pc, pcExec} = '0;
      {refC, refIe, refBip, refBe} = 4'b0;
      refPrev = '0;
      prevLive = 1'b0;
      repeat (5) @(posedge gclk);
      #1;
      grst = 1'b0;
      for (int i = 0; i < 32; i++) begin // Adder on registers
         r = randBits(3);
         runInstr(addOps[r[2:0]], isaPkg::srcReg, r[2] ? isaPkg::tgtImm : isaPkg::tgtReg,
                  16'h0, 5'h0, 5'h0, 1'b0);
      end
      for (int i = 0; i < 24; i++) begin // Logic, then shifts after a carry update
         r = randBits(16);
         runInstr(logicOps[r[1:0]], isaPkg::srcReg, isaPkg::tgtReg, 16'h0, 5'h0, 5'h0, 1'b0);
         runInstr(isaPkg::opAddc, isaPkg::srcReg, isaPkg::tgtReg, 16'h0, 5'h0, 5'h0, 1'b0);
         runInstr(isaPkg::opShift, isaPkg::srcReg, isaPkg::tgtReg, r[15:0], 5'h0, 5'h0, 1'b0);
      end
      for (int i = 0; i < 32; i++) begin // Forwarded and load-data operands
         r = randBits(8);
         runInstr(r[7] ? logicOps[r[1:0]] : addOps[r[2:0]],
                  r[3] ? isaPkg::srcLoad : isaPkg::srcFwd,
                  isaPkg::tgtSelT'(r[5:4]), 16'h0, 5'h0, 5'h0, 1'b0);
      end
      for (int i = 0; i < 24; i++) begin // Status register updates, some skipped
         r = randBits(8);
         runInstr(isaPkg::opMts, isaPkg::srcReg, isaPkg::tgtReg, {15'h0, r[0]}, 5'h0, 5'h0,
                  r[1]);
         runInstr(isaPkg::opRtid, isaPkg::srcReg, isaPkg::tgtReg, 16'h0, 5'h0, {4'h0, r[2]},
                  r[3]);
         runInstr(r[4] ? isaPkg::opBrk : isaPkg::opBrki, isaPkg::srcReg, isaPkg::tgtReg, 16'h0,
                  r[5] ? 5'h0E : 5'h0C, 5'h0, r[6]);
         runInstr(isaPkg::opRtbd, isaPkg::srcReg, isaPkg::tgtReg, 16'h0, 5'h0, 5'h2, r[7]);
         runInstr(isaPkg::opMfs, isaPkg::srcReg, isaPkg::tgtReg, {15'h0, r[0]}, 5'h0, 5'h0,
                  1'b0);
         runInstr(isaPkg::opAdd, isaPkg::srcReg, isaPkg::tgtReg, 16'h0, 5'h0, 5'h0, r[1]);
      end
      for (int i = 0; i < 18; i++) begin // Barrel shifts
         r = randBits(2);
         runInstr(barrelOps[i % 3], r[0] ? isaPkg::srcFwd : isaPkg::srcReg,
                  r[1] ? isaPkg::tgtImm : isaPkg::tgtReg, 16'h0, 5'h0, 5'h0, 1'b0);
      end
      for (int i = 0; i < 36; i++) begin // Byte lanes
         runInstr(memOps[i % 6], isaPkg::srcReg, isaPkg::tgtReg, 16'h0, 5'h0, 5'h0, 1'b0);
      end
      repeat (2) @(posedge gclk);
      $display("Checks: %0d  errors: %0d", checks, errCnt);
      if (errCnt == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// ==== tb/execUnit_assert.sv ====
`timescale 1ns/1ps

module execUnitAssert (
   input logic             gclk,
   input logic             grst,
   input logic             dEn,
   input isaPkg::opcodeT   opcode,
   input logic             stall,
   input logic [31:0]      rResult,
   input logic             rMsrIe,
   input logic [3:0]       rDwbSel
);
   logic barrelIssue;

   assign barrelIssue = dEn && (opcode inside {isaPkg::opBsr, isaPkg::opBsra, isaPkg::opBsl});

   // Barrel issue waits exactly one cycle
   stallOneCycle: assert property (@(posedge gclk) disable iff (grst)
      barrelIssue |=> stall ##1 !stall)
      else $error("barrel issue did not stall for exactly one cycle");

   // Stall only after a barrel issue
   stallCause: assert property (@(posedge gclk) disable iff (grst)
      stall |-> $past(barrelIssue))
      else $error("stall without a barrel issue");

   // No issue during the barrel wait
   noIssueInStall: assert property (@(posedge gclk) disable iff (grst) !(dEn && stall))
      else $error("dEn high while stall is high");

   resetOutputs: assert property (@(posedge gclk)
      grst |=> (rResult == 32'h0 && !rMsrIe && rDwbSel == 4'h0 && !stall))
      else $error("outputs not cleared by reset");

endmodule

bind execUnit execUnitAssert uAssert (
   .gclk, .grst, .dEn, .opcode, .stall, .rResult, .rMsrIe, .rDwbSel
);
